// File: verilog.f
+incdir+.
mem_pkg.sv
agu_stage.sv
data_ram.sv
mem_stage.sv
writeback_unit.sv
mem_subsystem.sv
mem_properties.sv
tb_mem_subsystem.sv

// File: tb_mem_subsystem.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module tb_mem_subsystem;
	import mem_pkg::*;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [`XLEN-1:0] in_pc;
	instr_u in_ins;
	logic commit_valid;
	logic commit_ready;
	mem_wb_t commit;

	logic [`XLEN-1:0] t_pc [64];
	logic [31:0] t_ins [64];
	logic t_we [64];
	logic [4:0] t_rd [64];
	logic [`XLEN-1:0] t_data [64];
	int n_rows = 0;
	int sent = 0;
	int got = 0;
	int errors = 0;
	logic [31:0] seed = 32'h74d473af;
	logic in_fire = 1'b0;

	mem_subsystem u_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_ins(in_ins),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready),
		.commit(commit)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic append_row(input logic [31:0] ins);
		t_pc[n_rows] = 64'h1000 + 4 * n_rows;
		t_ins[n_rows] = ins;
		n_rows++;
	endtask

	task automatic addi_op(input int rd, input int rs1, input int imm);
		append_row({imm[11:0], rs1[4:0], 3'b000, rd[4:0], `OP_IMM});
	endtask

	task automatic load_op(input logic [2:0] f3, input int rd, input int rs1, input int imm);
		append_row({imm[11:0], rs1[4:0], f3, rd[4:0], `OP_LOAD});
	endtask

	task automatic store_op(input logic [2:0] f3, input int rs2, input int rs1, input int imm);
		append_row({imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OP_STORE});
	endtask

	task automatic build_program();
		addi_op(10, 0, 'h100); // base, word 0x20 after wrap
		addi_op(1, 0, -1);
		store_op(3'd3, 1, 10, 0); // x1 straight from the bypass
		addi_op(2, 0, -2047);
		store_op(3'd3, 2, 10, 8);
		addi_op(3, 0, 'h5a3);
		store_op(3'd0, 3, 10, 1);
		store_op(3'd1, 3, 10, 6);
		store_op(3'd2, 3, 10, 12);
		load_op(3'd3, 4, 10, 0);
		load_op(3'd3, 5, 10, 8);
		for (int k = 0; k < 8; k++) begin
			load_op(3'd0, 6 + k % 4, 10, k);
			load_op(3'd4, 7, 10, k);
		end
		for (int k = 0; k < 8; k += 2) begin
			load_op(3'd1, 8, 10, k);
			load_op(3'd5, 9, 10, k);
		end
		for (int k = 0; k < 8; k += 4) begin
			load_op(3'd2, 6, 10, k);
			load_op(3'd6, 7, 10, k);
		end
		addi_op(12, 0, 'h110);
		store_op(3'd3, 12, 10, 16);
		load_op(3'd3, 13, 10, 16); // word just written
		load_op(3'd3, 14, 13, 0); // loaded value as base
		load_op(3'd2, 15, 14, -8);
		addi_op(0, 0, 'h55);
		store_op(3'd3, 0, 10, 24);
		load_op(3'd3, 17, 10, 24);
		append_row({7'd0, 5'd2, 5'd1, 3'd0, 5'd5, 7'b011_0011}); // R-type add
		addi_op(18, 5, 1);
	endtask

	// walks the table over a model register file and RAM
	task automatic run_model();
		logic [`XLEN-1:0] rf [`REG_NUM];
		logic [`XLEN-1:0] ram [`DRAM_WORDS];
		logic [31:0] w;
		logic [`XLEN-1:0] ea;
		logic [`XLEN-1:0] v;
		int nbytes;
		int lane;
		int idx;
		foreach (rf[r])
			rf[r] = '0;
		foreach (ram[r])
			ram[r] = '0;
		for (int i = 0; i < n_rows; i++) begin
			w = t_ins[i];
			t_rd[i] = w[11:7];
			t_we[i] = 1'b0;
			t_data[i] = '0;
			if (w[6:0] == `OP_STORE)
				ea = rf[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
			else
				ea = rf[w[19:15]] + {{52{w[31]}}, w[31:20]};
			nbytes = 1 << w[13:12];
			lane = ea[2:0] / nbytes * nbytes; // low bits below size ignored
			idx = int'(((ea - `DRAM_BASE) >> 3) % `DRAM_WORDS);
			case (w[6:0])
				`OP_IMM: begin
					t_we[i] = w[11:7] != 5'd0;
					t_data[i] = ea;
				end
				`OP_STORE: begin
					for (int b = 0; b < nbytes; b++)
						ram[idx][(lane + b) * 8 +: 8] = rf[w[24:20]][b * 8 +: 8];
					t_data[i] = ea;
				end
				`OP_LOAD: begin
					v = '0;
					for (int b = 0; b < 8; b++) begin
						if (b < nbytes)
							v[b * 8 +: 8] = ram[idx][(lane + b) * 8 +: 8];
						else if (!w[14])
							v[b * 8 +: 8] = {8{v[nbytes * 8 - 1]}};
					end
					t_we[i] = w[11:7] != 5'd0;
					t_data[i] = v;
				end
				default: ;
			endcase
			if (t_we[i])
				rf[t_rd[i]] = t_data[i];
		end
	endtask

	task automatic check_commit();
		if (got >= sent) begin
			errors++;
			$display("commit %0d came out before its instruction was sent", got);
		end
		if (commit.pc !== t_pc[got]) begin
			errors++;
			$display("Fail row %0d commit.pc: got %h expected %h", got, commit.pc, t_pc[got]);
		end
		if (commit.ins !== t_ins[got]) begin
			errors++;
			$display("Fail row %0d commit.ins: got %h expected %h", got, commit.ins, t_ins[got]);
		end
		if (commit.reg_we !== t_we[got]) begin
			errors++;
			$display("Fail row %0d commit.reg_we: got %h expected %h", got, commit.reg_we,
				t_we[got]);
		end
		if (t_we[got] && commit.rd !== t_rd[got]) begin
			errors++;
			$display("Fail row %0d commit.rd: got %h expected %h", got, commit.rd, t_rd[got]);
		end
		if (commit.data !== t_data[got]) begin
			errors++;
			$display("Fail row %0d commit.data: got %h expected %h", got, commit.data,
				t_data[got]);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_ins = '0;
		commit_ready = 1'b0;
		build_program();
		run_model();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (got < n_rows) begin
			@(negedge clk);
			if (in_fire)
				in_valid = 1'b0;
			if (!in_valid && sent < n_rows && (lcg_next() >> 30) != 0) begin
				in_valid = 1'b1;
				in_pc = t_pc[sent];
				in_ins = t_ins[sent];
			end
			commit_ready = (lcg_next() >> 29) > 1; // stall about one cycle in four
			#2;
			if (commit_valid && sent == 0) begin
				errors++;
				$display("commit_valid high before any instruction was sent");
			end
			if (commit_valid && commit_ready) begin
				check_commit();
				got++;
			end
			in_fire = in_valid && in_ready;
			if (in_fire)
				sent++;
		end
		@(negedge clk);
		in_valid = 1'b0;
		commit_ready = 1'b1;
		repeat (4) begin
			#2;
			if (commit_valid) begin
				errors++;
				$display("extra commit after the last row");
			end
			@(negedge clk);
		end
		errors += u_dut.u_mem.u_props.fail_count; // assertion failures in the mem stage
		$display("errors: %0d, commits checked: %0d of %0d", errors, got, n_rows);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// run limit counted from the end of reset
	initial begin
		@(negedge reset);
		repeat (n_rows * 20) @(posedge clk);
		$display("timeout with %0d of %0d commits seen, errors: %0d", got, n_rows, errors);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: mem_properties.sv
`timescale 1ns/10ps

module mem_properties (
	input logic clk,
	input logic reset,
	input logic wb_valid,
	input logic wb_ready,
	input mem_pkg::mem_wb_t wb_out,
	input logic ram_we
);

	int fail_count = 0;

	// stalled result must wait unchanged
	property hold_on_stall;
		@(posedge clk) disable iff (reset)
			wb_valid && !wb_ready |=> wb_valid && $stable(wb_out);
	endproperty

	property empty_after_reset;
		@(posedge clk) reset |=> !wb_valid;
	endproperty

	// a store that wrote has left the stage by the next cycle
	property write_on_transfer;
		@(posedge clk) disable iff (reset)
			ram_we |=> !wb_valid || $changed(wb_out.pc);
	endproperty

	a_hold: assert property (hold_on_stall) else begin
		fail_count++;
		$error("mem stage item changed or dropped while writeback stalled");
	end
	a_reset: assert property (empty_after_reset) else begin
		fail_count++;
		$error("mem stage valid high in the cycle after reset");
	end
	a_write: assert property (write_on_transfer) else begin
		fail_count++;
		$error("RAM write without an outgoing transfer");
	end

endmodule

bind mem_stage mem_properties u_props (
	.clk(clk),
	.reset(reset),
	.wb_valid(wb_valid),
	.wb_ready(wb_ready),
	.wb_out(wb_out),
	.ram_we(ram_we)
);

// File: mem_subsystem.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_subsystem (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [`XLEN-1:0] in_pc,
	input mem_pkg::instr_u in_ins,
	output logic commit_valid,
	input logic commit_ready,
	output mem_pkg::mem_wb_t commit
);
	import mem_pkg::*;

	logic [4:0] rs1_idx;
	logic [4:0] rs2_idx;
	logic [`XLEN-1:0] rs1_rf;
	logic [`XLEN-1:0] rs2_rf;
	bypass_t mem_bypass;
	bypass_t wb_bypass;
	logic ex_valid;
	logic ex_ready;
	ex_mem_t ex_bus;
	logic wb_valid;
	logic wb_ready;
	mem_wb_t wb_bus;

	agu_stage u_agu (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_ins(in_ins),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_rf(rs1_rf),
		.rs2_rf(rs2_rf),
		.mem_bypass(mem_bypass),
		.wb_bypass(wb_bypass),
		.ex_valid(ex_valid),
		.ex_ready(ex_ready),
		.ex_out(ex_bus)
	);

	mem_stage u_mem (
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_ready(ex_ready),
		.ex_in(ex_bus),
		.wb_valid(wb_valid),
		.wb_ready(wb_ready),
		.wb_out(wb_bus),
		.mem_bypass(mem_bypass)
	);

	writeback_unit u_wb (
		.clk(clk),
		.reset(reset),
		.wb_valid(wb_valid),
		.wb_ready(wb_ready),
		.wb_in(wb_bus),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_rf(rs1_rf),
		.rs2_rf(rs2_rf),
		.wb_bypass(wb_bypass),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready),
		.commit(commit)
	);

endmodule

// File: writeback_unit.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module writeback_unit (
	input logic clk,
	input logic reset,
	input logic wb_valid,
	output logic wb_ready,
	input mem_pkg::mem_wb_t wb_in,
	input logic [4:0] rs1_idx,
	input logic [4:0] rs2_idx,
	output logic [`XLEN-1:0] rs1_rf,
	output logic [`XLEN-1:0] rs2_rf,
	output mem_pkg::bypass_t wb_bypass,
	output logic commit_valid,
	input logic commit_ready,
	output mem_pkg::mem_wb_t commit
);
	import mem_pkg::*;

	logic cm_valid;
	mem_wb_t rec;
	logic [`XLEN-1:0] rf [`REG_NUM];

	assign wb_ready = commit_ready | ~cm_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			cm_valid <= 1'b0;
		end else if (wb_ready) begin
			cm_valid <= wb_valid;
		end
		if (wb_valid && wb_ready)
			rec <= wb_in;
	end

	// architectural state is written when the record retires
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_NUM; i++)
				rf[i] <= '0;
		end else if (cm_valid && commit_ready && rec.reg_we) begin
			rf[rec.rd] <= rec.data;
		end
	end

	assign rs1_rf = (rs1_idx == 5'd0) ? '0 : rf[rs1_idx];
	assign rs2_rf = (rs2_idx == 5'd0) ? '0 : rf[rs2_idx];

	assign wb_bypass.we = cm_valid & rec.reg_we; // not yet in rf
	assign wb_bypass.rd = rec.rd;
	assign wb_bypass.data = rec.data;

	assign commit_valid = cm_valid;
	assign commit = rec;

endmodule

// File: mem_stage.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_stage (
	input logic clk,
	input logic reset,
	input logic ex_valid,
	output logic ex_ready,
	input mem_pkg::ex_mem_t ex_in,
	output logic wb_valid,
	input logic wb_ready,
	output mem_pkg::mem_wb_t wb_out,
	output mem_pkg::bypass_t mem_bypass
);
	import mem_pkg::*;

	logic ms_valid;
	ex_mem_t item;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [`XLEN-1:0] offset;
	logic [`DRAM_IDX_W-1:0] ram_idx;
	logic [2:0] lane;
	logic [7:0] size_mask;
	logic [`XLEN-1:0] ram_rdata;
	logic [`XLEN-1:0] shifted;
	logic [`XLEN-1:0] ld_val;
	logic [`XLEN-1:0] result;
	logic ram_we;

	assign ex_ready = wb_ready | ~ms_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			ms_valid <= 1'b0;
		end else if (ex_ready) begin
			ms_valid <= ex_valid;
		end
		if (ex_valid && ex_ready)
			item <= ex_in;
	end

	assign opcode = item.ins.i_view.opcode;
	assign funct3 = item.ins.i_view.funct3;
	assign offset = item.addr - `DRAM_BASE;
	assign ram_idx = offset[`DRAM_IDX_W+2:3]; // word index, wraps

	// lane aligned down to access size
	always_comb begin
		case (funct3[1:0])
			2'd0: begin
				lane = item.addr[2:0];
				size_mask = 8'h01;
			end
			2'd1: begin
				lane = {item.addr[2:1], 1'b0};
				size_mask = 8'h03;
			end
			2'd2: begin
				lane = {item.addr[2], 2'b00};
				size_mask = 8'h0f;
			end
			default: begin
				lane = 3'd0;
				size_mask = 8'hff;
			end
		endcase
	end

	assign ram_we = ms_valid && wb_ready && opcode == `OP_STORE; // once, on leaving

	data_ram u_ram (
		.clk(clk),
		.rd_idx(ram_idx),
		.rd_data(ram_rdata),
		.wr_en(ram_we),
		.wr_idx(ram_idx),
		.wr_mask(size_mask << lane),
		.wr_data(item.store_data << {lane, 3'b000})
	);

	assign shifted = ram_rdata >> {lane, 3'b000};

	always_comb begin
		case (funct3)
			3'b000: ld_val = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
			3'b001: ld_val = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
			3'b010: ld_val = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
			3'b011: ld_val = shifted;
			3'b100: ld_val = {{(`XLEN-8){1'b0}}, shifted[7:0]};
			3'b101: ld_val = {{(`XLEN-16){1'b0}}, shifted[15:0]};
			3'b110: ld_val = {{(`XLEN-32){1'b0}}, shifted[31:0]};
			default: ld_val = '0;
		endcase
		if (opcode == `OP_LOAD)
			result = ld_val;
		else if (opcode == `OP_STORE || opcode == `OP_IMM)
			result = item.addr;
		else
			result = '0; // unknown op
	end

	assign wb_valid = ms_valid;
	assign wb_out.pc = item.pc;
	assign wb_out.ins = item.ins;
	assign wb_out.reg_we = item.reg_we;
	assign wb_out.rd = item.rd;
	assign wb_out.data = result;

	assign mem_bypass.we = ms_valid & item.reg_we;
	assign mem_bypass.rd = item.rd;
	assign mem_bypass.data = result;

endmodule

// File: data_ram.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module data_ram (
	input logic clk,
	input logic [`DRAM_IDX_W-1:0] rd_idx,
	output logic [`XLEN-1:0] rd_data,
	input logic wr_en,
	input logic [`DRAM_IDX_W-1:0] wr_idx,
	input logic [7:0] wr_mask,
	input logic [`XLEN-1:0] wr_data
);

	logic [`XLEN-1:0] mem [`DRAM_WORDS];

	assign rd_data = mem[rd_idx]; // async read

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < 8; b++) begin
				if (wr_mask[b])
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

endmodule

// File: agu_stage.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module agu_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [`XLEN-1:0] in_pc,
	input mem_pkg::instr_u in_ins,
	output logic [4:0] rs1_idx,
	output logic [4:0] rs2_idx,
	input logic [`XLEN-1:0] rs1_rf,
	input logic [`XLEN-1:0] rs2_rf,
	input mem_pkg::bypass_t mem_bypass,
	input mem_pkg::bypass_t wb_bypass,
	output logic ex_valid,
	input logic ex_ready,
	output mem_pkg::ex_mem_t ex_out
);
	import mem_pkg::*;

	logic ag_valid;
	logic [`XLEN-1:0] ag_pc;
	instr_u ag_ins;
	logic [6:0] opcode;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;

	// youngest producer wins
	function automatic logic [`XLEN-1:0] pick_operand(input logic [4:0] idx,
		input logic [`XLEN-1:0] rf_val, input bypass_t mb, input bypass_t wb);
		if (mb.we && mb.rd == idx)
			return mb.data;
		else if (wb.we && wb.rd == idx)
			return wb.data;
		return rf_val;
	endfunction

	assign in_ready = ex_ready | ~ag_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			ag_valid <= 1'b0;
		end else if (in_ready) begin
			ag_valid <= in_valid;
		end
		if (in_valid && in_ready) begin
			ag_pc <= in_pc;
			ag_ins <= in_ins;
		end
	end

	assign opcode = ag_ins.i_view.opcode;
	assign rs1_idx = ag_ins.i_view.rs1; // same bits in both views
	assign rs2_idx = ag_ins.s_view.rs2;

	always_comb begin
		if (opcode == `OP_STORE)
			imm = {{(`XLEN-12){ag_ins.s_view.imm_hi[6]}}, ag_ins.s_view.imm_hi,
				ag_ins.s_view.imm_lo};
		else
			imm = {{(`XLEN-12){ag_ins.i_view.imm12[11]}}, ag_ins.i_view.imm12};
	end

	assign rs1_val = pick_operand(rs1_idx, rs1_rf, mem_bypass, wb_bypass);
	assign rs2_val = pick_operand(rs2_idx, rs2_rf, mem_bypass, wb_bypass);

	assign ex_valid = ag_valid;
	assign ex_out.pc = ag_pc;
	assign ex_out.ins = ag_ins;
	assign ex_out.addr = rs1_val + imm;
	assign ex_out.store_data = rs2_val;
	assign ex_out.reg_we = (opcode == `OP_LOAD || opcode == `OP_IMM)
		&& ag_ins.i_view.rd != 5'd0; // x0 never written
	assign ex_out.rd = ag_ins.i_view.rd;

endmodule

// File: mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// same 32-bit word, view picked by opcode
	typedef union packed {
		i_fmt_t i_view; // loads, addi
		s_fmt_t s_view; // stores
	} instr_u;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		instr_u ins;
		logic [`XLEN-1:0] addr; // effective address or addi sum
		logic [`XLEN-1:0] store_data; // rs2 value
		logic reg_we;
		logic [4:0] rd;
	} ex_mem_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		instr_u ins;
		logic reg_we;
		logic [4:0] rd;
		logic [`XLEN-1:0] data;
	} mem_wb_t;

	typedef struct packed {
		logic we;
		logic [4:0] rd;
		logic [`XLEN-1:0] data;
	} bypass_t;

endpackage

// File: mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and address width
`define XLEN 64

// RAM window, index wraps outside it
`define DRAM_BASE 64'h0000_0000_8000_0000
`define DRAM_WORDS 256
`define DRAM_IDX_W 8

// integer register file
`define REG_NUM 32

// major opcodes
`define OP_LOAD 7'b000_0011
`define OP_STORE 7'b010_0011
`define OP_IMM 7'b001_0011

`endif
